// ==== ex_stage.sv ====
`default_nettype none

module ex_stage (
    input  wire logic           clk,
    input  wire logic           rst_n,
    input  wire logic           stall,
    input  wire rv_pkg::id_ex_t id_ex,
    output rv_pkg::wb_t         wb,
    output logic                redirect,
    output rv_pkg::word_t       redirect_pc
);

    rv_pkg::wb_t   wb_q;
    rv_pkg::word_t rs1_val;
    rv_pkg::word_t rs2_val;
    rv_pkg::word_t op_a;
    rv_pkg::word_t op_b;
    rv_pkg::word_t alu_out;
    rv_pkg::word_t result;
    rv_pkg::word_t pc_plus4;
    logic          fwd_ok;
    logic          taken;

    // bypass from the instruction one ahead
    assign fwd_ok  = wb_q.valid && wb_q.reg_write && (wb_q.rd != '0);
    assign rs1_val = (fwd_ok && wb_q.rd == id_ex.ctrl.rs1) ? wb_q.data : id_ex.rs1_data;
    assign rs2_val = (fwd_ok && wb_q.rd == id_ex.ctrl.rs2) ? wb_q.data : id_ex.rs2_data;

    assign op_a     = id_ex.ctrl.alu_pc ? id_ex.pc : rs1_val;
    assign op_b     = id_ex.ctrl.alu_imm ? id_ex.imm : rs2_val;
    assign pc_plus4 = id_ex.pc + 32'd4;

    always_comb begin
        case (id_ex.ctrl.alu_ctrl)
            rv_pkg::ALU_SUB:   alu_out = op_a - op_b;
            rv_pkg::ALU_SLL:   alu_out = op_a << op_b[4:0];
            rv_pkg::ALU_SLT:   alu_out = {31'b0, $signed(op_a) < $signed(op_b)};
            rv_pkg::ALU_SLTU:  alu_out = {31'b0, op_a < op_b};
            rv_pkg::ALU_XOR:   alu_out = op_a ^ op_b;
            rv_pkg::ALU_SRL:   alu_out = op_a >> op_b[4:0];
            rv_pkg::ALU_SRA:   alu_out = $signed(op_a) >>> op_b[4:0];
            rv_pkg::ALU_OR:    alu_out = op_a | op_b;
            rv_pkg::ALU_AND:   alu_out = op_a & op_b;
            rv_pkg::ALU_PASSB: alu_out = op_b;
            default:           alu_out = op_a + op_b;
        endcase
    end

    assign result = id_ex.ctrl.link ? pc_plus4 : alu_out;

    always_comb begin
        case (id_ex.ctrl.br_func)
            rv_pkg::BR_EQ:     taken = (rs1_val == rs2_val);
            rv_pkg::BR_NE:     taken = (rs1_val != rs2_val);
            rv_pkg::BR_LT:     taken = $signed(rs1_val) < $signed(rs2_val);
            rv_pkg::BR_GE:     taken = $signed(rs1_val) >= $signed(rs2_val);
            rv_pkg::BR_LTU:    taken = rs1_val < rs2_val;
            rv_pkg::BR_GEU:    taken = rs1_val >= rs2_val;
            rv_pkg::BR_ALWAYS: taken = 1'b1;
            default:           taken = 1'b0;
        endcase
    end

    assign redirect = id_ex.valid && taken;

    always_comb begin
        case (id_ex.ctrl.pc_source)
            rv_pkg::PC_BRANCH: redirect_pc = id_ex.pc + id_ex.imm;
            rv_pkg::PC_REG:    redirect_pc = (rs1_val + id_ex.imm) & ~32'd1;
            default:           redirect_pc = pc_plus4;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_q <= '0;
        end else if (!stall) begin
            wb_q.valid     <= id_ex.valid;
            wb_q.reg_write <= id_ex.valid && id_ex.ctrl.reg_write;
            wb_q.rd        <= id_ex.ctrl.rd;
            wb_q.data      <= result;
        end
    end

    // a held result is shown once, after the hold ends
    always_comb begin
        wb       = wb_q;
        wb.valid = wb_q.valid && !stall;
    end

    a_redirect_needs_valid: assert property (@(posedge clk) disable iff (!rst_n)
        redirect |-> id_ex.valid)
        else $error("redirect from an empty EX slot");

endmodule

`default_nettype wire

// ==== fetch_unit.sv ====
`default_nettype none

module fetch_unit #(
    parameter rv_pkg::word_t reset_pc = '0
) (
    input  wire logic          clk,
    input  wire logic          rst_n,
    input  wire logic          stall,
    input  wire logic          flush,
    input  wire logic          redirect,
    input  wire rv_pkg::word_t redirect_pc,
    input  wire rv_pkg::word_t imem_data,
    output rv_pkg::word_t      imem_addr,
    output rv_pkg::if_id_t     if_id
);

    rv_pkg::word_t pc_q;

    assign imem_addr = pc_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc_q <= reset_pc;
        end else if (!stall) begin
            pc_q <= redirect ? redirect_pc : pc_q + 32'd4;
        end
    end

    // fetched word lands here one cycle after its address
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            if_id <= '0;
        end else if (!stall) begin
            if_id.valid <= !flush;
            if_id.pc    <= pc_q;
            if_id.instr <= imem_data;
        end
    end

endmodule

`default_nettype wire

// ==== hazard_ctrl.sv ====
`default_nettype none

module hazard_ctrl (
    input  wire logic clk,
    input  wire logic rst_n,
    input  wire logic hold,
    input  wire logic redirect,
    output logic      stall,
    output logic      flush
);

    rv_pkg::hz_state_t state;
    rv_pkg::hz_state_t state_nxt;

    // hold wins over everything
    assign stall = hold;
    assign flush = redirect && !hold && (state != rv_pkg::HZ_REDIRECT);

    always_comb begin
        if (hold) begin
            state_nxt = rv_pkg::HZ_HOLD;
        end else if (flush) begin
            state_nxt = rv_pkg::HZ_REDIRECT;
        end else begin
            state_nxt = rv_pkg::HZ_RUN;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= rv_pkg::HZ_RUN;
        end else begin
            state <= state_nxt;
        end
    end

    a_no_stall_and_flush: assert property (@(posedge clk) disable iff (!rst_n)
        !(stall && flush))
        else $error("stall and flush raised together");

endmodule

`default_nettype wire

// ==== id_decode.sv ====
`default_nettype none

module id_decode (
    input  wire rv_pkg::if_id_t if_id,
    output rv_pkg::ctrl_t       ctrl,
    output rv_pkg::word_t       imm
);

    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;

    rv_pkg::word_t instr;
    logic [6:0]    opcode;
    logic [2:0]    funct3;

    assign instr  = if_id.instr;
    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];

    // shared by OP and OP-IMM; addi has no sub form
    function automatic rv_pkg::alu_ctrl_t alu_op(input logic [2:0] f3, input logic alt,
                                                 input logic is_imm);
        rv_pkg::alu_ctrl_t op;
        case (f3)
            3'b000:  op = (alt && !is_imm) ? rv_pkg::ALU_SUB : rv_pkg::ALU_ADD;
            3'b001:  op = rv_pkg::ALU_SLL;
            3'b010:  op = rv_pkg::ALU_SLT;
            3'b011:  op = rv_pkg::ALU_SLTU;
            3'b100:  op = rv_pkg::ALU_XOR;
            3'b101:  op = alt ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
            3'b110:  op = rv_pkg::ALU_OR;
            default: op = rv_pkg::ALU_AND;
        endcase
        return op;
    endfunction

    always_comb begin
        ctrl           = '0;
        ctrl.alu_ctrl  = rv_pkg::ALU_ADD;
        ctrl.br_func   = rv_pkg::BR_NONE;
        ctrl.pc_source = rv_pkg::PC_INC;
        ctrl.rs1       = instr[19:15];
        ctrl.rs2       = instr[24:20];
        imm            = {{20{instr[31]}}, instr[31:20]};
        case (opcode)
            OPC_OP: begin
                ctrl.reg_write = 1'b1;
                ctrl.alu_ctrl  = alu_op(funct3, instr[30], 1'b0);
            end
            OPC_OP_IMM: begin
                ctrl.reg_write = 1'b1;
                ctrl.alu_imm   = 1'b1;
                ctrl.alu_ctrl  = alu_op(funct3, instr[30], 1'b1);
            end
            OPC_LUI, OPC_AUIPC: begin
                ctrl.reg_write = 1'b1;
                ctrl.alu_imm   = 1'b1;
                ctrl.alu_pc    = (opcode == OPC_AUIPC);
                ctrl.alu_ctrl  = (opcode == OPC_LUI) ? rv_pkg::ALU_PASSB : rv_pkg::ALU_ADD;
                imm            = {instr[31:12], 12'b0};
            end
            OPC_JAL: begin
                ctrl.reg_write = 1'b1;
                ctrl.link      = 1'b1;
                ctrl.br_func   = rv_pkg::BR_ALWAYS;
                ctrl.pc_source = rv_pkg::PC_BRANCH;
                imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
            end
            OPC_JALR: begin
                ctrl.reg_write = 1'b1;
                ctrl.link      = 1'b1;
                ctrl.br_func   = rv_pkg::BR_ALWAYS;
                ctrl.pc_source = rv_pkg::PC_REG;
            end
            OPC_BRANCH: begin
                ctrl.pc_source = rv_pkg::PC_BRANCH;
                imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
                case (funct3)
                    3'b000:  ctrl.br_func = rv_pkg::BR_EQ;
                    3'b001:  ctrl.br_func = rv_pkg::BR_NE;
                    3'b100:  ctrl.br_func = rv_pkg::BR_LT;
                    3'b101:  ctrl.br_func = rv_pkg::BR_GE;
                    3'b110:  ctrl.br_func = rv_pkg::BR_LTU;
                    3'b111:  ctrl.br_func = rv_pkg::BR_GEU;
                    default: ctrl.br_func = rv_pkg::BR_NONE;
                endcase
            end
            default: begin
            end
        endcase
        // non-writing instructions retire with rd zero
        ctrl.rd = ctrl.reg_write ? instr[11:7] : '0;
    end

    // a register-relative target only comes with an unconditional jump
    a_reg_target_is_jump: assert property (@(if_id)
        !(if_id.valid && ctrl.pc_source == rv_pkg::PC_REG) || ctrl.br_func == rv_pkg::BR_ALWAYS)
        else $error("PC_REG target decoded without BR_ALWAYS");

endmodule

`default_nettype wire

// ==== id_ex_buffer.sv ====
`default_nettype none

module id_ex_buffer (
    input  wire logic          clk,
    input  wire logic          rst_n,
    input  wire logic          stall,
    input  wire logic          flush,
    input  wire logic          valid,
    input  wire rv_pkg::ctrl_t ctrl,
    input  wire rv_pkg::word_t pc,
    input  wire rv_pkg::word_t rs1_data,
    input  wire rv_pkg::word_t rs2_data,
    input  wire rv_pkg::word_t imm,
    output rv_pkg::id_ex_t     id_ex
);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            id_ex                <= '0;
            id_ex.ctrl.alu_ctrl  <= rv_pkg::ALU_ADD;
            id_ex.ctrl.br_func   <= rv_pkg::BR_NONE;
            id_ex.ctrl.pc_source <= rv_pkg::PC_INC;
        end else if (!stall) begin
            if (flush) begin
                // bubble; data fields are left as they were
                id_ex.valid          <= 1'b0;
                id_ex.ctrl.rs1       <= '0;
                id_ex.ctrl.rs2       <= '0;
                id_ex.ctrl.rd        <= '0;
                id_ex.ctrl.reg_write <= 1'b0;
                id_ex.ctrl.alu_ctrl  <= rv_pkg::ALU_ADD;
                id_ex.ctrl.alu_pc    <= 1'b0;
                id_ex.ctrl.alu_imm   <= 1'b0;
                id_ex.ctrl.link      <= 1'b0;
                id_ex.ctrl.br_func   <= rv_pkg::BR_NONE;
            end else begin
                id_ex.valid    <= valid;
                id_ex.ctrl     <= ctrl;
                id_ex.pc       <= pc;
                id_ex.rs1_data <= rs1_data;
                id_ex.rs2_data <= rs2_data;
                id_ex.imm      <= imm;
            end
        end
    end

endmodule

`default_nettype wire

// ==== reg_file.sv ====
`default_nettype none

module reg_file (
    input  wire logic            clk,
    input  wire logic            rst_n,
    input  wire rv_pkg::reg_idx_t rs1,
    input  wire rv_pkg::reg_idx_t rs2,
    input  wire rv_pkg::wb_t     wb,
    output rv_pkg::word_t        rs1_data,
    output rv_pkg::word_t        rs2_data
);

    rv_pkg::word_t regs [31:1];
    logic          wr_en;

    assign wr_en = wb.valid && wb.reg_write && (wb.rd != '0);

    always_ff @(posedge clk) begin
        if (wr_en) begin
            regs[wb.rd] <= wb.data;
        end
    end

    // same-cycle write is visible to the reader
    function automatic rv_pkg::word_t read_port(input rv_pkg::reg_idx_t idx);
        if (idx == '0) begin
            return '0;
        end
        if (wr_en && wb.rd == idx) begin
            return wb.data;
        end
        return regs[idx];
    endfunction

    always_comb begin
        rs1_data = read_port(rs1);
        rs2_data = read_port(rs2);
    end

    a_x0_reads_zero: assert property (@(posedge clk) disable iff (!rst_n)
        (rs1 != '0 || rs1_data == '0) && (rs2 != '0 || rs2_data == '0))
        else $error("x0 read returned a non-zero value");

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# build with Verilator, run, and look for the pass line in the output
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module rv_pipe_tb -f tb.f -o rv_pipe_sim &&
    ./obj_dir/rv_pipe_sim | tee /dev/stderr | grep "TB PASSED" > /dev/null &&
    echo "run.sh: simulation passed" ||
    { echo "run.sh: simulation failed"; exit 1; }

// ==== rv_pipe_stim.txt ====
# I <word address> <instruction>: program image in hex, text after it is ignored
# E <rd> <value>: expected retires in order in hex, value not compared when rd is 0
I 00 00500093 addi x1, x0, 5
I 01 ffd00113 addi x2, x0, -3
I 02 002081b3 add x3, x1, x2
I 03 40118233 sub x4, x3, x1
I 04 001222b3 slt x5, x4, x1
I 05 12345337 lui x6, 0x12345
I 06 67830313 addi x6, x6, 0x678
I 07 00001397 auipc x7, 0x1
I 08 40115413 srai x8, x2, 1
I 09 0ff34493 xori x9, x6, 0xff
I 0a 00708013 addi x0, x1, 7
I 0b 00100533 add x10, x0, x1
I 0c 00308463 beq x1, x3, +8 not taken
I 0d 00114663 blt x2, x1, +12 taken
I 0e 00100f93 addi x31, x0, 1 squashed
I 0f 00200f93 addi x31, x0, 2 squashed
I 10 00117663 bgeu x2, x1, +12 taken
I 11 00300f93 addi x31, x0, 3 squashed
I 12 00400f93 addi x31, x0, 4 squashed
I 13 00c0066f jal x12, +12
I 14 00500f93 addi x31, x0, 5 squashed
I 15 00600f93 addi x31, x0, 6 squashed
I 16 06300693 addi x13, x0, 0x63
I 17 00668767 jalr x14, 6(x13)
I 18 00700f93 addi x31, x0, 7 squashed
I 19 00800f93 addi x31, x0, 8 squashed
I 1a 00e607b3 add x15, x12, x14
I 1b 40f70833 sub x16, x14, x15
I 1c 010068b3 or x17, x0, x16
E 01 00000005
E 02 fffffffd
E 03 00000002
E 04 fffffffd
E 05 00000001
E 06 12345000
E 06 12345678
E 07 0000101c
E 08 fffffffe
E 09 12345687
E 00 00000000 write to x0
E 0a 00000005
E 00 00000000 beq
E 00 00000000 blt
E 00 00000000 bgeu
E 0c 00000050
E 0d 00000063
E 0e 00000060
E 0f 000000b0
E 10 ffffffb0
E 11 ffffffb0

// ==== rv_pipe_tb.sv ====
`default_nettype none

module rv_pipe_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam logic [31:0]   MAX_WORDS    = 32'd64;
    localparam int            MAX_RETIRES  = 64;
    localparam int            RETIRE_LIMIT = 2000;
    localparam int            DRAIN_NOPS   = 6;
    localparam int            DRAIN_LIMIT  = 200;
    localparam rv_pkg::word_t NOP          = 32'h0000_0013;
    localparam rv_pkg::word_t RESET_PC     = 32'h0000_0000;

    logic             clk;
    logic             rst_n;
    logic             hold;
    rv_pkg::word_t    imem_data;
    rv_pkg::word_t    imem_addr;
    logic             retire_valid;
    rv_pkg::reg_idx_t retire_rd;
    rv_pkg::word_t    retire_data;

    rv_pkg::word_t    imem [0:MAX_WORDS-1];
    logic [29:0]      prog_words;
    rv_pkg::reg_idx_t exp_rd [0:MAX_RETIRES-1];
    rv_pkg::word_t    exp_data [0:MAX_RETIRES-1];
    int               exp_count;
    int               retired;
    int               drained;
    int               errors;
    logic             hold_en;
    logic [31:0]      rnd_state;

    rv_pipe_top #(
        .reset_pc (RESET_PC)
    ) u_rv_pipe_top (
        .clk          (clk),
        .rst_n        (rst_n),
        .hold         (hold),
        .imem_data    (imem_data),
        .imem_addr    (imem_addr),
        .retire_valid (retire_valid),
        .retire_rd    (retire_rd),
        .retire_data  (retire_data)
    );

    // instruction memory answers in the same cycle
    assign imem_data = (imem_addr[31:2] < prog_words) ? imem[imem_addr[7:2]] : NOP;

    always #4 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // roughly one hold cycle in five
    always @(posedge clk) begin
        logic use_rand;
        use_rand = rst_n && hold_en;
        #1;
        if (use_rand) begin
            rnd_state = xorshift32(rnd_state);
            hold = ((rnd_state % 32'd5) == 32'd0);
        end else begin
            hold = 1'b0;
        end
    end

    task automatic load_stim();
        int          fd;
        string       line;
        logic [31:0] a;
        logic [31:0] d;
        fd = $fopen("rv_pipe_stim.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("could not open rv_pipe_stim.txt");
            return;
        end
        while ($fgets(line, fd) != 0) begin
            if ($sscanf(line, "I %h %h", a, d) == 2) begin
                if (a < MAX_WORDS) begin
                    imem[a[5:0]] = d;
                    if (a[29:0] >= prog_words) begin
                        prog_words = a[29:0] + 30'd1;
                    end
                end else begin
                    errors++;
                    $display("program word address %0h is outside the memory model", a);
                end
            end else if ($sscanf(line, "E %h %h", a, d) == 2) begin
                if (exp_count < MAX_RETIRES) begin
                    exp_rd[exp_count]   = a[4:0];
                    exp_data[exp_count] = d;
                    exp_count++;
                end
            end
        end
        $fclose(fd);
        if (exp_count == 0) begin
            errors++;
            $display("no expected retires found in the stimulus file");
        end
    endtask

    task automatic check_retire();
        if (retired < exp_count) begin
            if (retire_rd !== exp_rd[retired]) begin
                errors++;
                $display("ERROR retire_rd got 0x%h expected 0x%h at retire %0d",
                         retire_rd, exp_rd[retired], retired);
            end
            // data only means something for a written register
            if (exp_rd[retired] != '0 && retire_data !== exp_data[retired]) begin
                errors++;
                $display("ERROR retire_data got 0x%h expected 0x%h at retire %0d",
                         retire_data, exp_data[retired], retired);
            end
            retired++;
        end else begin
            if (retire_rd !== '0 || retire_data !== '0) begin
                errors++;
                $display("ERROR retire_rd/retire_data got 0x%h/0x%h expected NOP 0x00/0x00000000",
                         retire_rd, retire_data);
            end
            drained++;
        end
    endtask

    // outputs settle well before the falling edge
    always @(negedge clk) begin
        if (rst_n) begin
            if (retire_valid && hold) begin
                errors++;
                $display("an instruction retired while hold was high");
            end
            if (retire_valid) begin
                check_retire();
            end
        end
    end

    initial begin
        int cycles;
        clk        = 1'b0;
        rst_n      = 1'b0;
        hold       = 1'b0;
        hold_en    = 1'b0;
        rnd_state  = 32'd97;
        prog_words = '0;
        exp_count  = 0;
        retired    = 0;
        drained    = 0;
        errors     = 0;
        load_stim();
        repeat (4) @(posedge clk);
        #1;
        // state while reset is still applied
        if (imem_addr !== RESET_PC) begin
            errors++;
            $display("ERROR imem_addr got 0x%h expected 0x%h in reset", imem_addr, RESET_PC);
        end
        if (retire_valid !== 1'b0) begin
            errors++;
            $display("ERROR retire_valid got 0x%h expected 0x0 in reset", retire_valid);
        end
        rst_n   = 1'b1;
        hold_en = 1'b1;

        cycles = 0;
        while (retired < exp_count && cycles < RETIRE_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        if (retired < exp_count) begin
            errors++;
            $display("timeout: only %0d of %0d expected retires seen", retired, exp_count);
        end else begin
            cycles = 0;
            while (drained < DRAIN_NOPS && cycles < DRAIN_LIMIT) begin
                @(posedge clk);
                cycles++;
            end
            if (drained < DRAIN_NOPS) begin
                errors++;
                $display("timeout: the trailing NOPs did not retire");
            end
        end

        $display("retires %0d of %0d, trailing NOPs %0d, errors %0d",
                 retired, exp_count, drained, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== rv_pipe_top.sv ====
`default_nettype none

module rv_pipe_top #(
    parameter rv_pkg::word_t reset_pc = '0
) (
    input  wire logic          clk,
    input  wire logic          rst_n,
    input  wire logic          hold,
    input  wire rv_pkg::word_t imem_data,
    output rv_pkg::word_t      imem_addr,
    output logic               retire_valid,
    output rv_pkg::reg_idx_t   retire_rd,
    output rv_pkg::word_t      retire_data
);

    rv_pkg::if_id_t if_id;
    rv_pkg::ctrl_t  ctrl;
    rv_pkg::word_t  imm;
    rv_pkg::word_t  rs1_data;
    rv_pkg::word_t  rs2_data;
    rv_pkg::id_ex_t id_ex;
    rv_pkg::wb_t    wb;
    rv_pkg::word_t  redirect_pc;
    logic           redirect;
    logic           stall;
    logic           flush;

    fetch_unit #(
        .reset_pc (reset_pc)
    ) u_fetch_unit (
        .clk         (clk),
        .rst_n       (rst_n),
        .stall       (stall),
        .flush       (flush),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .imem_data   (imem_data),
        .imem_addr   (imem_addr),
        .if_id       (if_id)
    );

    id_decode u_id_decode (
        .if_id (if_id),
        .ctrl  (ctrl),
        .imm   (imm)
    );

    reg_file u_reg_file (
        .clk      (clk),
        .rst_n    (rst_n),
        .rs1      (if_id.instr[19:15]),
        .rs2      (if_id.instr[24:20]),
        .wb       (wb),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    id_ex_buffer u_id_ex_buffer (
        .clk      (clk),
        .rst_n    (rst_n),
        .stall    (stall),
        .flush    (flush),
        .valid    (if_id.valid),
        .ctrl     (ctrl),
        .pc       (if_id.pc),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .imm      (imm),
        .id_ex    (id_ex)
    );

    ex_stage u_ex_stage (
        .clk         (clk),
        .rst_n       (rst_n),
        .stall       (stall),
        .id_ex       (id_ex),
        .wb          (wb),
        .redirect    (redirect),
        .redirect_pc (redirect_pc)
    );

    hazard_ctrl u_hazard_ctrl (
        .clk      (clk),
        .rst_n    (rst_n),
        .hold     (hold),
        .redirect (redirect),
        .stall    (stall),
        .flush    (flush)
    );

    assign retire_valid = wb.valid;
    assign retire_rd    = wb.rd;
    assign retire_data  = wb.data;

endmodule

`default_nettype wire

// ==== rv_pkg.sv ====
`default_nettype none

package rv_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_PASSB
    } alu_ctrl_t;

    typedef enum logic [2:0] {
        BR_NONE,
        BR_EQ,
        BR_NE,
        BR_LT,
        BR_GE,
        BR_LTU,
        BR_GEU,
        BR_ALWAYS
    } br_func_t;

    // redirect target is pc + 4, pc + imm or rs1 + imm
    typedef enum logic [1:0] {
        PC_INC,
        PC_BRANCH,
        PC_REG
    } pc_source_t;

    typedef enum logic [1:0] {
        HZ_RUN,
        HZ_HOLD,
        HZ_REDIRECT
    } hz_state_t;

    typedef struct packed {
        reg_idx_t   rs1;
        reg_idx_t   rs2;
        reg_idx_t   rd;
        logic       reg_write;
        alu_ctrl_t  alu_ctrl;
        logic       alu_pc;
        logic       alu_imm;
        logic       link;
        br_func_t   br_func;
        pc_source_t pc_source;
    } ctrl_t;

    typedef struct packed {
        logic  valid;
        word_t pc;
        word_t instr;
    } if_id_t;

    typedef struct packed {
        logic  valid;
        ctrl_t ctrl;
        word_t pc;
        word_t rs1_data;
        word_t rs2_data;
        word_t imm;
    } id_ex_t;

    typedef struct packed {
        logic     valid;
        logic     reg_write;
        reg_idx_t rd;
        word_t    data;
    } wb_t;

endpackage

`default_nettype wire

// ==== tb.f ====
rv_pkg.sv
fetch_unit.sv
id_decode.sv
reg_file.sv
id_ex_buffer.sv
ex_stage.sv
hazard_ctrl.sv
rv_pipe_top.sv
rv_pipe_tb.sv
